// File: bench/mips_cpu_tb.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_cpu_tb import mips_pkg::*; ();

    // total run is a few hundred cycles, this leaves ample margin
    localparam int MAX_CYCLES = 2000;

    // primary opcodes and special function codes
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_LUI   = 6'h0f;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] FNC_ADDU  = 6'h21;
    localparam logic [5:0] FNC_SUBU  = 6'h23;
    localparam logic [5:0] FNC_AND   = 6'h24;
    localparam logic [5:0] FNC_OR    = 6'h25;
    localparam logic [5:0] FNC_SLT   = 6'h2a;
    localparam logic [5:0] FNC_JR    = 6'h08;

    logic  clk;
    logic  reset;
    logic  prog_write;
    word_t prog_address;
    word_t prog_writedata;
    logic  active;
    word_t register_v0;

    int    cycle_count = 0;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    word_t program_words[$];

    mips_cpu mips_cpu_i (
        .clk            (clk),
        .reset          (reset),
        .prog_write     (prog_write),
        .prog_address   (prog_address),
        .prog_writedata (prog_writedata),
        .active         (active),
        .register_v0    (register_v0)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // watchdog in case the core never halts
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: core still running after %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    function automatic word_t encode_rtype(logic [5:0] fn, int rd, int rs, int rt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
    endfunction

    function automatic word_t encode_itype(logic [5:0] op, int rt, int rs, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // jr $0 ends every program
    function automatic word_t halt_word();
        return encode_rtype(FNC_JR, 0, 0, 0);
    endfunction

    // reset 2 cycles, load through the port, release and wait for halt
    task automatic run_program(output int active_cycles);
        reset = 1'b1;
        next_cycle();
        next_cycle();
        foreach (program_words[i]) begin
            prog_write     = 1'b1;
            prog_address   = `MIPS_RESET_VECTOR + 4 * i;
            prog_writedata = program_words[i];
            next_cycle();
        end
        prog_write = 1'b0;
        reset      = 1'b0;
        active_cycles = 0;
        while (!active) begin
            next_cycle();
        end
        // one retired instruction per cycle of active
        while (active) begin
            next_cycle();
            active_cycles++;
        end
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed", name);
            tests_failed++;
        end
    endtask

    // v0 = (((a+b) & (a-b)) | slt(a,b)) - a
    task automatic arith_logic();
        int          start;
        int          cycles;
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        word_t       a;
        word_t       b;
        word_t       expected;
        start = errors;
        for (int n = 0; n < 4; n++) begin
            imm_a = 16'($urandom);
            imm_b = 16'($urandom);
            a = {{16{imm_a[15]}}, imm_a};
            b = {{16{imm_b[15]}}, imm_b};
            expected = ((a + b) & (a - b)) | (($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
            expected = expected - a;
            program_words.delete();
            program_words.push_back(encode_itype(OPC_ADDIU, 8, 0, imm_a));
            program_words.push_back(encode_itype(OPC_ADDIU, 9, 0, imm_b));
            program_words.push_back(encode_rtype(FNC_ADDU, 10, 8, 9));
            program_words.push_back(encode_rtype(FNC_SUBU, 11, 8, 9));
            program_words.push_back(encode_rtype(FNC_AND, 12, 10, 11));
            program_words.push_back(encode_rtype(FNC_SLT, 13, 8, 9));
            program_words.push_back(encode_rtype(FNC_OR, 14, 12, 13));
            program_words.push_back(encode_rtype(FNC_SUBU, 2, 14, 8));
            program_words.push_back(halt_word());
            run_program(cycles);
            check_value($sformatf("arith_logic[%0d]", n), expected, register_v0);
        end
        report_test("arith_logic", start);
    endtask

    // fixed image words as the core sees them
    task automatic preloaded_data();
        int          start;
        int          cycles;
        logic [15:0] addr [3];
        word_t       expected [3];
        start = errors;
        addr[0] = 16'h0000;
        addr[1] = 16'h0004;
        addr[2] = 16'h0100 + 16'(4 * $urandom_range(28, 0));
        expected[0] = 32'h1000_0000;
        expected[1] = 32'hf000_0000;
        expected[2] = 32'hffff_ffff;
        for (int n = 0; n < 3; n++) begin
            program_words.delete();
            program_words.push_back(encode_itype(OPC_LW, 2, 0, addr[n]));
            program_words.push_back(halt_word());
            run_program(cycles);
            check_value($sformatf("preloaded_data[%h]", addr[n]), expected[n], register_v0);
        end
        report_test("preloaded_data", start);
    endtask

    task automatic store_load_roundtrip();
        int          start;
        int          cycles;
        word_t       value;
        logic [15:0] addr;
        logic [15:0] upper;
        start = errors;
        value = $urandom;
        addr  = 16'h0200 + 16'(4 * $urandom_range(16'h0dff, 1));
        // addiu sign-extends, so carry bit 15 into the upper half
        upper = value[31:16] + {15'd0, value[15]};
        program_words.delete();
        program_words.push_back(encode_itype(OPC_LUI, 8, 0, upper));
        program_words.push_back(encode_itype(OPC_ADDIU, 8, 8, value[15:0]));
        program_words.push_back(encode_itype(OPC_SW, 8, 0, addr));
        program_words.push_back(encode_itype(OPC_LW, 2, 0, addr));
        program_words.push_back(halt_word());
        run_program(cycles);
        check_value("store_load_roundtrip", value, register_v0);
        // stored little-endian inside the array
        check_value("store_load_roundtrip byte order",
                    {value[7:0], value[15:8], value[23:16], value[31:24]},
                    mips_cpu_i.data_ram_i.mem[addr[13:2]]);
        report_test("store_load_roundtrip", start);
    endtask

    // taken branch skips the +1, v0 ends at 16, else 17
    task automatic branch_paths();
        int          start;
        int          cycles;
        logic        use_bne;
        logic        equal;
        logic        taken;
        logic [15:0] x;
        logic [15:0] y;
        start = errors;
        for (int n = 0; n < 4; n++) begin
            use_bne = n[1];
            equal   = n[0];
            x = 16'($urandom);
            y = equal ? x : (x ^ 16'h0001);
            taken = use_bne ? !equal : equal;
            program_words.delete();
            program_words.push_back(encode_itype(OPC_ADDIU, 8, 0, x));
            program_words.push_back(encode_itype(OPC_ADDIU, 9, 0, y));
            program_words.push_back(encode_itype(use_bne ? OPC_BNE : OPC_BEQ, 9, 8, 16'd1));
            program_words.push_back(encode_itype(OPC_ADDIU, 2, 2, 16'd1));
            program_words.push_back(encode_itype(OPC_ADDIU, 2, 2, 16'd16));
            program_words.push_back(halt_word());
            run_program(cycles);
            check_value($sformatf("branch_paths[%s %s]", use_bne ? "bne" : "beq",
                                  equal ? "equal" : "differ"),
                        taken ? 32'd16 : 32'd17, register_v0);
        end
        report_test("branch_paths", start);
    endtask

    task automatic halt_and_zero();
        int start;
        int cycles;
        int executed;
        start = errors;
        program_words.delete();
        program_words.push_back(encode_itype(OPC_ADDIU, 2, 0, 16'd7));
        // would leak into v0 if $0 were writable
        program_words.push_back(encode_itype(OPC_ADDIU, 0, 0, 16'h1234));
        program_words.push_back(encode_rtype(FNC_ADDU, 2, 0, 0));
        program_words.push_back(halt_word());
        executed = program_words.size();
        // sits past the jr, a core that keeps going bumps v0
        program_words.push_back(encode_itype(OPC_ADDIU, 2, 2, 16'd1));
        run_program(cycles);
        check_value("halt_and_zero v0", 32'h0, register_v0);
        check_value("halt_and_zero cycles", 32'(executed), 32'(cycles));
        // frozen core keeps its state
        for (int n = 0; n < 10; n++) begin
            next_cycle();
            assert (!active) else begin
                $display("halt_and_zero: core became active again after halt");
                errors++;
            end
            check_value("halt_and_zero hold", 32'h0, register_v0);
        end
        report_test("halt_and_zero", start);
    endtask

    initial begin
        reset          = 1'b1;
        prog_write     = 1'b0;
        prog_address   = '0;
        prog_writedata = '0;
        void'($urandom(38));
        arith_logic();
        preloaded_data();
        store_load_roundtrip();
        branch_paths();
        halt_and_zero();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t alu_op,
    output word_t   result,
    output logic    zero
);

    logic a_lt_b;

    // two's complement compare for slt
    assign a_lt_b = $signed(a) < $signed(b);

    always_comb begin
        case (alu_op)
            // addu, addiu and address calculation
            ALU_ADD: result = a + b;
            // subu and branch compare, wraps
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {31'd0, a_lt_b};
            // immediate to the upper half, a ignored
            ALU_LUI: result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // equal operands on sub give zero
    assign zero = (result == '0);

endmodule

// File: design/data_ram.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module data_ram import mips_pkg::*; (
    input  logic  clk,
    input  word_t data_address,
    input  logic  data_write,
    input  logic  data_read,
    input  word_t data_writedata,
    output word_t data_readdata
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    // words kept little-endian, core sees big-endian
    word_t mem [`DMEM_WORDS];

    logic [IDX_W-1:0] word_idx;

    // byte swap, its own inverse
    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // byte address to word index, upper bits wrap
    assign word_idx = data_address[IDX_W+1:2];

    // fixed test image in core byte order
    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
        mem[0] = swap_bytes(32'h1000_0000);
        mem[1] = swap_bytes(32'hf000_0000);
        // 29 words of all ones from 100h up to 170h
        for (int i = 0; i < 29; i++) begin
            mem[(32'h100 >> 2) + i] = swap_bytes(32'hffff_ffff);
        end
    end

    // combinational read, zero when not selected
    assign data_readdata = data_read ? swap_bytes(mem[word_idx]) : '0;

    // store swapped back to little-endian
    always_ff @(posedge clk) begin
        if (data_write) begin
            mem[word_idx] <= swap_bytes(data_writedata);
        end
    end

    // lw and sw must use aligned addresses
    assert property (@(posedge clk) (data_read || data_write) |-> (data_address[1:0] == 2'b00));

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import mips_pkg::*; (
    input  word_t    instr,
    input  logic     active,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output reg_idx_t rd,
    output word_t    imm,
    output alu_op_t  alu_op,
    output logic     alu_src_imm,
    output logic     reg_write,
    output logic     reg_dst_rd,
    output logic     mem_to_reg,
    output logic     mem_write,
    output logic     mem_read,
    output logic     branch_eq,
    output logic     branch_ne,
    output logic     jump_reg
);

    opcode_t opcode;
    funct_t  funct;

    // field split, same positions for every format
    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    // sign-extended 16-bit immediate
    assign imm = {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        // defaults form a no-op
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        reg_dst_rd  = 1'b0;
        mem_to_reg  = 1'b0;
        mem_write   = 1'b0;
        mem_read    = 1'b0;
        branch_eq   = 1'b0;
        branch_ne   = 1'b0;
        jump_reg    = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                reg_dst_rd = 1'b1;
                case (funct)
                    FN_ADDU: begin
                        alu_op    = ALU_ADD;
                        reg_write = 1'b1;
                    end
                    FN_SUBU: begin
                        alu_op    = ALU_SUB;
                        reg_write = 1'b1;
                    end
                    FN_AND: begin
                        alu_op    = ALU_AND;
                        reg_write = 1'b1;
                    end
                    FN_OR: begin
                        alu_op    = ALU_OR;
                        reg_write = 1'b1;
                    end
                    FN_SLT: begin
                        alu_op    = ALU_SLT;
                        reg_write = 1'b1;
                    end
                    // target comes straight from rs_data
                    FN_JR: jump_reg = 1'b1;
                    default: reg_dst_rd = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            OP_LUI: begin
                alu_op      = ALU_LUI;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            // base plus offset on the adder
            OP_LW: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                mem_to_reg  = 1'b1;
                mem_read    = 1'b1;
            end
            OP_SW: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            // compare by subtraction, zero flag decides
            OP_BEQ: begin
                alu_op    = ALU_SUB;
                branch_eq = 1'b1;
            end
            OP_BNE: begin
                alu_op    = ALU_SUB;
                branch_ne = 1'b1;
            end
            default: alu_op = ALU_ADD;
        endcase

        // idle or halted core changes no state
        if (!active) begin
            reg_write = 1'b0;
            mem_write = 1'b0;
            mem_read  = 1'b0;
            branch_eq = 1'b0;
            branch_ne = 1'b0;
            jump_reg  = 1'b0;
        end
    end

    // a store never writes back a register
    assert final (!(mem_write && reg_write));

endmodule

// File: design/instr_rom.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module instr_rom import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  prog_write,
    input  word_t prog_address,
    input  word_t prog_writedata,
    input  word_t pc,
    output word_t instr
);

    localparam int IDX_W = $clog2(`IMEM_WORDS);
    localparam word_t IMEM_BYTES = `IMEM_WORDS * 4;

    word_t mem [`IMEM_WORDS];

    word_t fetch_off;
    word_t prog_off;
    logic  fetch_in_range;
    logic  prog_in_range;

    // byte offset from the reset vector
    // addresses below it wrap high and fall out of range
    assign fetch_off = pc - `MIPS_RESET_VECTOR;
    assign prog_off  = prog_address - `MIPS_RESET_VECTOR;

    assign fetch_in_range = fetch_off < IMEM_BYTES;
    assign prog_in_range  = prog_off < IMEM_BYTES;

    // loader only while the core sits in reset
    always_ff @(posedge clk) begin
        if (reset && prog_write && prog_in_range) begin
            mem[prog_off[IDX_W+1:2]] <= prog_writedata;
        end
    end

    // outside the array reads zero, an sll no-op
    assign instr = fetch_in_range ? mem[fetch_off[IDX_W+1:2]] : '0;

endmodule

// File: design/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// address of the first fetched instruction
`define MIPS_RESET_VECTOR 32'h0000_0400

// a jr to this address ends the run
`define MIPS_HALT_ADDR 32'h0000_0000

// instruction store depth in words
`define IMEM_WORDS 256

// data store depth in words
// word index taken from address bits above the byte offset
`define DMEM_WORDS 4096

`endif

// File: design/mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    // program load port, honored in reset only
    input  logic  prog_write,
    input  word_t prog_address,
    input  word_t prog_writedata,
    output logic  active,
    output word_t register_v0
);

    // fetch
    word_t    pc;
    word_t    instr;

    // decode
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    imm;
    alu_op_t  alu_op;
    logic     alu_src_imm;
    logic     reg_write;
    logic     reg_dst_rd;
    logic     mem_to_reg;
    logic     mem_write;
    logic     mem_read;
    logic     branch_eq;
    logic     branch_ne;
    logic     jump_reg;

    // operands and results
    word_t    rs_data;
    word_t    rt_data;
    word_t    alu_b;
    word_t    result;
    logic     zero;
    word_t    data_readdata;
    word_t    wr_data;
    reg_idx_t wr_idx;

    // operand b: register or sign-extended immediate
    assign alu_b = alu_src_imm ? imm : rt_data;

    // write-back: load data or alu result
    assign wr_data = mem_to_reg ? data_readdata : result;

    // r-type writes rd, immediate forms write rt
    assign wr_idx = reg_dst_rd ? rd : rt;

    pc_unit pc_unit_i (
        .clk       (clk),
        .reset     (reset),
        .branch_eq (branch_eq),
        .branch_ne (branch_ne),
        .jump_reg  (jump_reg),
        .zero      (zero),
        .imm       (imm),
        .rs_data   (rs_data),
        .pc        (pc),
        .active    (active)
    );

    instr_rom instr_rom_i (
        .clk            (clk),
        .reset          (reset),
        .prog_write     (prog_write),
        .prog_address   (prog_address),
        .prog_writedata (prog_writedata),
        .pc             (pc),
        .instr          (instr)
    );

    instr_decoder instr_decoder_i (
        .instr       (instr),
        .active      (active),
        .rs          (rs),
        .rt          (rt),
        .rd          (rd),
        .imm         (imm),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .reg_write   (reg_write),
        .reg_dst_rd  (reg_dst_rd),
        .mem_to_reg  (mem_to_reg),
        .mem_write   (mem_write),
        .mem_read    (mem_read),
        .branch_eq   (branch_eq),
        .branch_ne   (branch_ne),
        .jump_reg    (jump_reg)
    );

    reg_file reg_file_i (
        .clk         (clk),
        .reset       (reset),
        .rs          (rs),
        .rt          (rt),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .reg_write   (reg_write),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    alu alu_i (
        .a      (rs_data),
        .b      (alu_b),
        .alu_op (alu_op),
        .result (result),
        .zero   (zero)
    );

    data_ram data_ram_i (
        .clk            (clk),
        .data_address   (result),
        .data_write     (mem_write),
        .data_read      (mem_read),
        .data_writedata (rt_data),
        .data_readdata  (data_readdata)
    );

endmodule

// File: design/mips_pkg.sv
package mips_pkg;

    // data word and byte address
    typedef logic [31:0] word_t;

    // register number, $0 to $31
    typedef logic [4:0] reg_idx_t;

    // primary opcodes in use
    // anything else decodes as a no-op
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function codes under SPECIAL
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    // alu operation select
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

endpackage

// File: design/pc_unit.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module pc_unit import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  branch_eq,
    input  logic  branch_ne,
    input  logic  jump_reg,
    input  logic  zero,
    input  word_t imm,
    input  word_t rs_data,
    output word_t pc,
    output logic  active
);

    // idle until the first edge out of reset, then run until halt
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HALT
    } run_state_t;

    run_state_t state;
    word_t      pc_plus4;
    word_t      next_pc;
    logic       branch_taken;
    logic       halt_taken;

    assign pc_plus4 = pc + 32'd4;

    // enables arrive already gated by active
    assign branch_taken = (branch_eq && zero) || (branch_ne && !zero);
    assign halt_taken = jump_reg && (rs_data == `MIPS_HALT_ADDR);

    // no delay slot, target follows directly
    always_comb begin
        if (jump_reg) begin
            next_pc = rs_data;
        end else if (branch_taken) begin
            next_pc = pc_plus4 + (imm << 2);
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= `MIPS_RESET_VECTOR;
            state <= ST_IDLE;
        end else begin
            case (state)
                // first cycle out of reset fetches but does not retire
                ST_IDLE: state <= ST_RUN;
                ST_RUN: begin
                    if (halt_taken) begin
                        // pc left where the jr sits
                        state <= ST_HALT;
                    end else begin
                        pc <= next_pc;
                    end
                end
                default: state <= ST_HALT;
            endcase
        end
    end

    assign active = (state == ST_RUN);

    // fetch never sees a misaligned pc
    assert property (@(posedge clk) disable iff (reset) active |-> (pc[1:0] == 2'b00));

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    input  logic     reg_write,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    register_v0
);

    // v0 sits at index 2
    localparam reg_idx_t V0_IDX = 5'd2;

    word_t regs [32];

    // write on the edge that ends the instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && (wr_idx != '0)) begin
            // $0 writes dropped so it stays zero
            regs[wr_idx] <= wr_data;
        end
    end

    // no bypass, same-cycle reads see the old value
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

    // observation tap
    assign register_v0 = regs[V0_IDX];

endmodule

// File: flist.f
+incdir+design
design/mips_pkg.sv
design/pc_unit.sv
design/instr_rom.sv
design/instr_decoder.sv
design/reg_file.sv
design/alu.sv
design/data_ram.sv
design/mips_cpu.sv
bench/mips_cpu_tb.sv
